/* Bender.yml */
package:
  name: mdio_station

sources:
  - mdio_pkg.sv
  - mdio_cmd_if.sv
  - mdio_regs.sv
  - mdio_frame_engine.sv
  - mdio_station_top.sv
  - target: simulation
    files:
      - tb_mdio_phy_model.sv
      - tb_mdio.sv

/* mdio_cmd_if.sv */
`timescale 1ns/1ps

interface mdio_cmd_if import mdio_pkg::*; ();

    logic        load;    // One-cycle start request
    mdio_frame_u frame;   // Complete frame with st and ta filled in
    logic        busy;
    logic        done;    // One-cycle pulse at end of frame
    logic        no_ack;  // Turnaround bit was not pulled low
    logic [15:0] rdata;

    // Register block side
    modport regs (
        output load,
        output frame,
        input  busy,
        input  done,
        input  no_ack,
        input  rdata
    );

    // Frame engine side
    modport engine (
        input  load,
        input  frame,
        output busy,
        output done,
        output no_ack,
        output rdata
    );

endinterface

/* mdio_frame_engine.sv */
`timescale 1ns/1ps

module mdio_frame_engine import mdio_pkg::*; (
    input  logic       mdc,
    input  logic       rst_n,
    input  logic       mdio_in,
    output logic       mdio_out,
    output logic       mdio_oe,
    mdio_cmd_if.engine cmd
);

    logic [CNT_W-1:0] bit_cnt;    // Bit now on the line
    logic [CNT_W-1:0] next_bit;   // Bit launched at the coming edge
    mdio_frame_u      frame_q;    // Shift copy of the command
    logic             is_read;
    logic             shift_en;
    logic             data_smp;   // Edge ends a read data bit
    logic [15:0]      rd_shift;

    assign next_bit  = bit_cnt + 1'b1;
    assign shift_en  = cmd.busy && (next_bit >= BIT_FRAME0) && (next_bit <= BIT_LAST);
    assign data_smp  = cmd.busy && is_read && (bit_cnt >= BIT_DATA0) && (bit_cnt <= BIT_LAST);
    assign cmd.rdata = rd_shift;

    // Sequencer, preamble bit 0 goes out at the load edge
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            cmd.busy <= 1'b0;
            cmd.done <= 1'b0;
            is_read  <= 1'b0;
            mdio_out <= 1'b1;   // Line idles high
            mdio_oe  <= 1'b0;
        end else if (cmd.load) begin
            bit_cnt  <= '0;
            cmd.busy <= 1'b1;
            is_read  <= (cmd.frame.f.op == OP_READ);
            mdio_out <= 1'b1;
            mdio_oe  <= 1'b1;
        end else if (cmd.busy) begin
            if (bit_cnt == BIT_END) begin
                cmd.busy <= 1'b0;
                cmd.done <= 1'b0;
            end else begin
                bit_cnt <= next_bit;
                if (next_bit == BIT_END) begin
                    cmd.done <= 1'b1;
                    mdio_out <= 1'b1;
                    mdio_oe  <= 1'b0;
                end else begin
                    // Preamble ones, then frame MSB first
                    if (next_bit < BIT_FRAME0) begin
                        mdio_out <= 1'b1;
                    end else begin
                        mdio_out <= frame_q.raw[FRAME_LEN-1];
                    end
                    if (is_read && (next_bit == BIT_TA0)) begin
                        mdio_oe <= 1'b0;   // PHY owns the line from here
                    end
                end
            end
        end
    end

    // Frame shifter
    always_ff @(posedge mdc) begin
        if (cmd.load) begin
            frame_q <= cmd.frame;
        end else if (shift_en) begin
            frame_q.raw <= {frame_q.raw[FRAME_LEN-2:0], 1'b0};
        end
    end

    // Second turnaround bit must be driven low by the PHY
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            cmd.no_ack <= 1'b0;
        end else if (cmd.load) begin
            cmd.no_ack <= 1'b0;
        end else if (cmd.busy && is_read && (bit_cnt == BIT_TA1)) begin
            cmd.no_ack <= mdio_in;
        end
    end

    // Read data in, MSB first
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            rd_shift <= '0;
        end else if (data_smp) begin
            rd_shift <= {rd_shift[14:0], mdio_in};
        end
    end

    // Output enable was dropped at turnaround and stays off for data
    a_oe_off_read_data: assert property (
        @(posedge mdc) disable iff (!rst_n)
        data_smp |-> !mdio_oe
    );

    // Register block holds load back while a frame runs
    a_no_load_busy: assert property (
        @(posedge mdc) disable iff (!rst_n)
        cmd.load |-> !cmd.busy
    );

endmodule

/* mdio_pkg.sv */
package mdio_pkg;

    // Wishbone side
    localparam int WB_DW = 32;
    localparam int WB_AW = 4;

    // Line sequence lengths
    localparam int PRE_LEN   = 32;
    localparam int FRAME_LEN = 32;
    localparam int CNT_W     = $clog2(PRE_LEN + FRAME_LEN + 1);

    // Clause 22 codes
    localparam logic [1:0] ST_CODE  = 2'b01;
    localparam logic [1:0] OP_WRITE = 2'b01;
    localparam logic [1:0] OP_READ  = 2'b10;
    localparam logic [1:0] TA_WRITE = 2'b10;

    // Register map
    localparam logic [WB_AW-1:0] REG_CMD    = 4'h0;
    localparam logic [WB_AW-1:0] REG_STATUS = 4'h4;
    localparam logic [WB_AW-1:0] REG_RDATA  = 4'h8;

    // Status bits
    localparam int STAT_BUSY   = 0;
    localparam int STAT_DONE   = 1;
    localparam int STAT_NO_ACK = 2;

    // Bit index on the line, preamble counted first
    localparam logic [CNT_W-1:0] BIT_FRAME0 = CNT_W'(PRE_LEN);       // First start bit
    localparam logic [CNT_W-1:0] BIT_TA0    = CNT_W'(PRE_LEN + 14);
    localparam logic [CNT_W-1:0] BIT_TA1    = CNT_W'(PRE_LEN + 15);
    localparam logic [CNT_W-1:0] BIT_DATA0  = CNT_W'(PRE_LEN + 16);
    localparam logic [CNT_W-1:0] BIT_LAST   = CNT_W'(PRE_LEN + FRAME_LEN - 1);
    localparam logic [CNT_W-1:0] BIT_END    = CNT_W'(PRE_LEN + FRAME_LEN);   // Done cycle

    // Management frame, first field goes out first
    typedef struct packed {
        logic [1:0]  st;
        logic [1:0]  op;
        logic [4:0]  phyad;
        logic [4:0]  regad;
        logic [1:0]  ta;
        logic [15:0] data;
    } mdio_frame_s;

    // Field view for decode, raw view for the serial shifter
    typedef union packed {
        mdio_frame_s             f;
        logic [FRAME_LEN-1:0]    raw;
    } mdio_frame_u;

endpackage

/* mdio_regs.sv */
`timescale 1ns/1ps

module mdio_regs import mdio_pkg::*; (
    input  logic             mdc,
    input  logic             rst_n,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [WB_AW-1:0] wb_adr,
    input  logic [WB_DW-1:0] wb_dat_w,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic             wb_ack,
    mdio_cmd_if.regs         cmd
);

    logic             req;       // New request, not yet acked
    logic             cmd_wr;
    logic             accept;    // Command write that starts a frame
    mdio_frame_u      wr_word;   // Bus word seen through the frame fields
    mdio_frame_u      frame_q;
    logic             done_q;
    logic             no_ack_q;
    logic [15:0]      rdata_q;
    logic [WB_DW-1:0] status;

    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign cmd_wr  = req && wb_we && (wb_adr == REG_CMD);
    assign accept  = cmd_wr && !cmd.busy && !cmd.load;   // Busy command writes are dropped

    assign wr_word.raw = wb_dat_w;
    assign cmd.frame   = frame_q;

    // Ack and load leave together one clock after the request
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            cmd.load <= 1'b0;
        end else begin
            wb_ack   <= req;
            cmd.load <= accept;
        end
    end

    // Command word, software gives op, addresses and data only
    always_ff @(posedge mdc) begin
        if (accept) begin
            frame_q.f.st    <= ST_CODE;
            frame_q.f.op    <= wr_word.f.op;
            frame_q.f.phyad <= wr_word.f.phyad;
            frame_q.f.regad <= wr_word.f.regad;
            frame_q.f.ta    <= TA_WRITE;
            frame_q.f.data  <= wr_word.f.data;
        end
    end

    // Sticky flags
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            no_ack_q <= 1'b0;
        end else if (accept) begin
            done_q   <= 1'b0;
            no_ack_q <= 1'b0;
        end else if (cmd.done) begin
            done_q   <= 1'b1;
            no_ack_q <= no_ack_q | cmd.no_ack;
        end
    end

    // Read data from the last frame
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (cmd.done) begin
            rdata_q <= cmd.rdata;
        end
    end

    always_comb begin
        status              = '0;
        status[STAT_BUSY]   = cmd.busy;    // Live, not sticky
        status[STAT_DONE]   = done_q;
        status[STAT_NO_ACK] = no_ack_q;
    end

    // Read mux, valid while the master holds the address
    always_comb begin
        case (wb_adr)
            REG_CMD:    wb_dat_r = frame_q.raw;
            REG_STATUS: wb_dat_r = status;
            REG_RDATA:  wb_dat_r = {16'h0000, rdata_q};
            default:    wb_dat_r = '0;
        endcase
    end

    // Master holds cyc and stb until it sees the ack
    a_ack_in_cycle: assert property (
        @(posedge mdc) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb)
    );

endmodule

/* mdio_station_top.sv */
`timescale 1ns/1ps

module mdio_station_top (
    input  logic        mdc,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        mdio_out,
    output logic        mdio_oe,
    input  logic        mdio_in
);

    // Command path between register block and engine
    mdio_cmd_if cmd_if ();

    mdio_regs mdio_regs_i (
        .mdc      (mdc),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cmd      (cmd_if.regs)
    );

    // Pad and pull-up sit outside
    mdio_frame_engine mdio_frame_engine_i (
        .mdc      (mdc),
        .rst_n    (rst_n),
        .mdio_in  (mdio_in),
        .mdio_out (mdio_out),
        .mdio_oe  (mdio_oe),
        .cmd      (cmd_if.engine)
    );

endmodule

/* sim.f */
mdio_pkg.sv
mdio_cmd_if.sv
mdio_regs.sv
mdio_frame_engine.sv
mdio_station_top.sv
tb_mdio_phy_model.sv
tb_mdio.sv

/* tb_mdio.sv */
`timescale 1ns/1ps

module tb_mdio import mdio_pkg::*; ();

    typedef struct packed {
        logic [1:0]  op;
        logic [4:0]  phyad;
        logic [4:0]  regad;
        logic [15:0] data;
        logic [15:0] exp_rdata;
        logic        exp_no_ack;
    } stim_row_t;

    logic        mdc;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        mdio_out;
    logic        mdio_oe;
    logic        mdio_line;
    logic        phy_out;
    logic        phy_oe;
    mdio_frame_u phy_frame;
    logic [7:0]  phy_pre;
    logic [7:0]  phy_count;
    stim_row_t   stim_rows [7];

    // Station first, then PHY, then pull-up
    assign mdio_line = mdio_oe ? mdio_out : (phy_oe ? phy_out : 1'b1);

    mdio_station_top mdio_station_top_i (.*, .mdio_in(mdio_line));
    tb_mdio_phy_model phy_model_i (.*);

    initial begin
        mdc = 1'b0;
        forever #10 mdc = ~mdc;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_frame(input string name, input mdio_frame_u exp, input mdio_frame_u act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp.raw, act.raw);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [WB_DW-1:0] exp,
                              input logic [WB_DW-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // One Wishbone classic cycle, released on the edge that sees the ack
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge mdc);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(posedge mdc);
        while (!wb_ack) begin
            if (waited == 10) begin
                $display("Timeout: no wb_ack for the access to address %h", adr);
                abort_run();
            end
            waited++;
            @(posedge mdc);
        end
        rdata  = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        wb_access(1'b0, REG_STATUS, '0, status);
        while (status[STAT_BUSY]) begin
            if (polls == 60) begin
                $display("Timeout: station still busy after %0d status polls", polls);
                abort_run();
            end
            polls++;
            wb_access(1'b0, REG_STATUS, '0, status);
        end
    endtask

    task automatic count_busy_cycles(output int n);
        n = 0;
        @(posedge mdc);
        while (mdio_station_top_i.cmd_if.busy) begin
            if (n == 200) begin
                $display("Timeout: busy never dropped after the command write");
                abort_run();
            end
            n++;
            @(posedge mdc);
        end
    endtask

    // Software leaves st and ta at zero
    function automatic logic [31:0] cmd_word(input stim_row_t row);
        mdio_frame_u w;
        w.raw     = '0;
        w.f.op    = row.op;
        w.f.phyad = row.phyad;
        w.f.regad = row.regad;
        w.f.data  = row.data;
        return w.raw;
    endfunction

    function automatic mdio_frame_u expected_frame(input stim_row_t row);
        mdio_frame_u e;
        e.f.st    = ST_CODE;
        e.f.op    = row.op;
        e.f.phyad = row.phyad;
        e.f.regad = row.regad;
        if (row.op == OP_WRITE) begin
            e.f.ta   = TA_WRITE;
            e.f.data = row.data;
        end else begin
            e.f.ta   = row.exp_no_ack ? 2'b11 : 2'b10;   // Pull-up, then PHY low if present
            e.f.data = row.exp_rdata;
        end
        return e;
    endfunction

    task automatic run_row(input stim_row_t row);
        logic [31:0] rd;
        logic [7:0]  count_before;
        count_before = phy_count;
        wb_access(1'b1, REG_CMD, cmd_word(row), rd);
        wait_idle();
        check_word("phy frame count", {24'h0, count_before} + 32'd1, {24'h0, phy_count});
        check_word("phy preamble ones", 32'd32, {24'h0, phy_pre});
        check_frame("phy frame", expected_frame(row), phy_frame);
        wb_access(1'b0, REG_STATUS, '0, rd);
        check_bit("status done", 1'b1, rd[STAT_DONE]);
        check_bit("status no_ack", row.exp_no_ack, rd[STAT_NO_ACK]);
        if (row.op == OP_READ) begin
            wb_access(1'b0, REG_RDATA, '0, rd);
            check_word("read data", {16'h0, row.exp_rdata}, rd);
        end else if (row.phyad == 5'd3) begin
            check_word("phy register", {16'h0, row.data}, {16'h0, phy_model_i.regs[row.regad]});
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [15:0] r0;
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] reg9_before;
        logic [7:0]  count_before;
        int          busy_cycles;
        stim_row_t   first;
        stim_row_t   second;
        void'($urandom(32'h71b8_9c87));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        r0 = 16'($urandom);
        r1 = 16'($urandom);
        r2 = 16'($urandom);
        stim_rows[0] = '{OP_WRITE, 5'd3, 5'd5,  r0, 16'h0000, 1'b0};
        stim_rows[1] = '{OP_WRITE, 5'd3, 5'd17, r1, 16'h0000, 1'b0};
        stim_rows[2] = '{OP_READ,  5'd3, 5'd5,  16'h0, r0, 1'b0};
        stim_rows[3] = '{OP_READ,  5'd3, 5'd17, 16'h0, r1, 1'b0};
        stim_rows[4] = '{OP_WRITE, 5'd3, 5'd31, r2, 16'h0000, 1'b0};
        stim_rows[5] = '{OP_READ,  5'd3, 5'd31, 16'h0, r2, 1'b0};
        stim_rows[6] = '{OP_READ,  5'd9, 5'd2,  16'h0, 16'hffff, 1'b1};   // Nobody answers
        repeat (16) @(posedge mdc);
        rst_n <= 1'b1;

        wb_access(1'b0, REG_STATUS, '0, rd);
        check_word("status after reset", 32'h0, rd);
        wb_access(1'b0, REG_RDATA, '0, rd);
        check_word("read data after reset", 32'h0, rd);
        wb_access(1'b0, 4'hc, '0, rd);
        check_word("unmapped address", 32'h0, rd);
        check_bit("mdio_oe after reset", 1'b0, mdio_oe);

        foreach (stim_rows[i]) begin
            run_row(stim_rows[i]);
        end

        wb_access(1'b1, REG_CMD, cmd_word(stim_rows[0]), rd);
        count_busy_cycles(busy_cycles);
        check_word("busy cycles after ack", 32'd65, busy_cycles);
        wait_idle();

        // Second command lands while the first frame runs
        first        = '{OP_WRITE, 5'd3, 5'd8, 16'($urandom), 16'h0, 1'b0};
        second       = '{OP_WRITE, 5'd3, 5'd9, 16'($urandom), 16'h0, 1'b0};
        count_before = phy_count;
        reg9_before  = phy_model_i.regs[9];
        wb_access(1'b1, REG_CMD, cmd_word(first), rd);
        wb_access(1'b1, REG_CMD, cmd_word(second), rd);
        wait_idle();
        check_word("frames after busy write", {24'h0, count_before} + 32'd1, {24'h0, phy_count});
        check_frame("frame after busy write", expected_frame(first), phy_frame);
        check_word("phy register 9", {16'h0, reg9_before}, {16'h0, phy_model_i.regs[9]});
        wb_access(1'b0, REG_CMD, '0, rd);
        check_word("command register", expected_frame(first).raw, rd);

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tb_mdio_phy_model.sv */
`timescale 1ns/1ps

module tb_mdio_phy_model import mdio_pkg::*; #(
    parameter logic [4:0] PHY_ADDR = 5'd3
) (
    input  logic        mdc,
    input  logic        rst_n,
    input  logic        mdio_line,   // Resolved bus line
    input  logic        mdio_oe,     // Station enable, only to count preamble ones
    output logic        phy_out,
    output logic        phy_oe,
    output mdio_frame_u phy_frame,   // Last complete frame seen on the line
    output logic [7:0]  phy_pre,     // Preamble ones in front of that frame
    output logic [7:0]  phy_count
);

    logic [15:0] regs [32];
    logic        in_frame;
    logic [4:0]  rx_idx;      // Frame bit being received
    logic [31:0] rx_bits;
    logic [7:0]  pre_run;
    logic        tx_active;
    logic [4:0]  tx_cnt;      // Zero during the first turnaround bit
    logic [15:0] tx_data;
    mdio_frame_u rx_word;     // Bits so far plus the one now on the line
    mdio_frame_u hdr;         // First 14 bits moved to the top for decode

    assign rx_word = {rx_bits[30:0], mdio_line};
    assign hdr     = {rx_bits[12:0], mdio_line, 18'h0};

    // Receive side, bits taken on the rising edge
    always_ff @(posedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= {3'b110, i[4:0], 3'b001, i[4:0]};
            end
            in_frame  <= 1'b0;
            rx_idx    <= '0;
            rx_bits   <= '0;
            pre_run   <= '0;
            tx_active <= 1'b0;
            tx_cnt    <= '0;
            tx_data   <= '0;
            phy_frame <= '0;
            phy_pre   <= '0;
            phy_count <= '0;
        end else begin
            if (mdio_oe && mdio_line) begin
                if (pre_run != 8'hff) pre_run <= pre_run + 1'b1;
            end else begin
                pre_run <= '0;
            end
            if (!in_frame) begin
                if (mdio_oe && !mdio_line) begin   // First start bit
                    in_frame <= 1'b1;
                    rx_idx   <= 5'd1;
                    rx_bits  <= '0;
                    phy_pre  <= pre_run;
                end
            end else begin
                rx_bits <= rx_word.raw;
                rx_idx  <= rx_idx + 1'b1;
                if (tx_active) tx_cnt <= tx_cnt + 1'b1;
                if (rx_idx == 5'd13 && hdr.f.op == OP_READ && hdr.f.phyad == PHY_ADDR) begin
                    tx_active <= 1'b1;
                    tx_cnt    <= '0;
                    tx_data   <= regs[hdr.f.regad];
                end
                if (rx_idx == 5'd31) begin
                    in_frame  <= 1'b0;
                    tx_active <= 1'b0;
                    phy_frame <= rx_word;
                    phy_count <= phy_count + 1'b1;
                    if (rx_word.f.op == OP_WRITE && rx_word.f.phyad == PHY_ADDR) begin
                        regs[rx_word.f.regad] <= rx_word.f.data;
                    end
                end
            end
        end
    end

    // Drive side changes after the falling edge
    always_ff @(negedge mdc or negedge rst_n) begin
        if (!rst_n) begin
            phy_oe  <= 1'b0;
            phy_out <= 1'b1;
        end else if (tx_active && tx_cnt == 5'd1) begin
            phy_oe  <= 1'b1;
            phy_out <= 1'b0;              // Second turnaround bit
        end else if (tx_active && tx_cnt >= 5'd2) begin
            phy_oe  <= 1'b1;
            phy_out <= tx_data[17 - tx_cnt];
        end else begin
            phy_oe  <= 1'b0;
            phy_out <= 1'b1;
        end
    end

endmodule
